/* Bender.yml */
package:
  name: hni_qos

sources:
  - chi_flit_pkg.sv
  - hni_qos_pkg.sv
  - rsp_fifo.sv
  - req_decode.sv
  - mshr_admit.sv
  - retry_bank.sv
  - pcrd_issue.sv
  - hni_qos_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_hni_qos.sv

/* chi_flit_pkg.sv */
// request, retry-ack and credit-grant flit layouts
// field set is trimmed to what QoS admission needs, no trace tag
`default_nettype none

package chi_flit_pkg;

    localparam int QOS_W      = 4;
    localparam int SRCID_W    = 7;
    localparam int TXNID_W    = 12;
    localparam int PCRDTYPE_W = 4;
    localparam int ADDR_W     = 44;
    localparam int OPCODE_W   = 7;

    typedef logic [QOS_W-1:0]      qos_t;
    typedef logic [SRCID_W-1:0]    srcid_t;
    typedef logic [TXNID_W-1:0]    txnid_t;
    typedef logic [PCRDTYPE_W-1:0] pcrdtype_t;

    // 86 bits
    typedef struct packed {
        qos_t                qos;
        srcid_t              tgtid;
        srcid_t              srcid;
        txnid_t              txnid;
        logic [OPCODE_W-1:0] opcode;
        logic [ADDR_W-1:0]   addr;
        logic                allowretry;
        pcrdtype_t           pcrdtype;
    } req_flit_t;

    typedef struct packed {
        srcid_t    srcid;
        txnid_t    txnid;
        qos_t      qos;
        pcrdtype_t pcrdtype;
    } retry_ack_t;

    typedef struct packed {
        srcid_t    srcid;
        qos_t      qos;
        pcrdtype_t pcrdtype;
    } pcrd_grant_t;

endpackage

`default_nettype wire

/* hni_qos_pkg.sv */
// home-node tracker sizes, QoS pool limits and internal request/retire records
// pool limits together must not exceed MSHR_ENTRIES
`default_nettype none

package hni_qos_pkg;

    localparam int MSHR_ENTRIES = 8;

    typedef logic [$clog2(MSHR_ENTRIES)-1:0] mshr_idx_t;
    typedef logic [MSHR_ENTRIES-1:0]         mshr_vec_t;
    typedef logic [2:0]                      pool_cnt_t;

    localparam pool_cnt_t HIGH_POOL_NUM = 3'd4;
    localparam pool_cnt_t LOW_POOL_NUM  = 3'd4;

    // classification thresholds and the QoS stamped on grants
    localparam chi_flit_pkg::qos_t QOS_HIGH_MIN   = 4'd8;
    localparam chi_flit_pkg::qos_t QOS_LOW_MAX    = 4'd7;
    localparam chi_flit_pkg::qos_t GRANT_QOS_HIGH = 4'd15;
    localparam chi_flit_pkg::qos_t GRANT_QOS_LOW  = 4'd0;

    localparam int RET_BANK_ENTRIES = 4;
    localparam int RET_CNT_W        = 4;

    typedef logic [RET_BANK_ENTRIES-1:0]         ret_vec_t;
    typedef logic [$clog2(RET_BANK_ENTRIES)-1:0] ret_idx_t;
    typedef logic [RET_CNT_W-1:0]                ret_cnt_t;

    localparam int RSP_FIFO_DEPTH = 4;

    typedef struct packed {
        logic                 valid;
        logic                 dyn;
        logic                 stat;
        logic                 high;
        logic                 low;
        chi_flit_pkg::srcid_t srcid;
        chi_flit_pkg::txnid_t txnid;
        chi_flit_pkg::qos_t   qos;
    } req_info_t;

    typedef struct packed {
        logic      valid;
        mshr_idx_t idx;
        logic      class_high;
    } retire_t;

endpackage

`default_nettype wire

/* hni_qos_top.sv */
// one request per cycle; retryack_won and pcrdgnt_won count only while valid is high
`timescale 1ns/10ps
`default_nettype none

module hni_qos_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          rxreq_valid,
    input  wire chi_flit_pkg::req_flit_t rxreq_flit,
    input  wire                          retryack_won,
    input  wire                          pcrdgnt_won,
    input  wire                          retire_valid,
    input  wire hni_qos_pkg::mshr_idx_t  retire_idx,
    output logic                         alloc_en,
    output chi_flit_pkg::req_flit_t      alloc_flit,
    output hni_qos_pkg::mshr_idx_t       alloc_idx,
    output logic                         retry_enable,
    output logic                         retryack_valid,
    output chi_flit_pkg::retry_ack_t     retryack,
    output logic                         pcrdgnt_valid,
    output chi_flit_pkg::pcrd_grant_t    pcrdgnt
);

    hni_qos_pkg::req_info_t req_info;
    hni_qos_pkg::retire_t   retire;
    chi_flit_pkg::srcid_t   grant_srcid;
    logic high_present, low_present, grant_valid, grant_high, grant_taken;

    req_decode u_decode (
        .rxreq_valid(rxreq_valid),
        .rxreq_flit (rxreq_flit),
        .req_info   (req_info)
    );

    mshr_admit u_admit (
        .clk         (clk),
        .rst         (rst),
        .req_info    (req_info),
        .rxreq_flit  (rxreq_flit),
        .retire_valid(retire_valid),
        .retire_idx  (retire_idx),
        .high_present(high_present),
        .low_present (low_present),
        .alloc_en    (alloc_en),
        .alloc_flit  (alloc_flit),
        .alloc_idx   (alloc_idx),
        .retry_enable(retry_enable),
        .retire      (retire)
    );

    retry_bank u_bank (
        .clk         (clk),
        .rst         (rst),
        .req_info    (req_info),
        .retry_enable(retry_enable),
        .retire      (retire),
        .grant_taken (grant_taken),
        .high_present(high_present),
        .low_present (low_present),
        .grant_valid (grant_valid),
        .grant_high  (grant_high),
        .grant_srcid (grant_srcid)
    );

    pcrd_issue u_issue (
        .clk           (clk),
        .rst           (rst),
        .req_info      (req_info),
        .retry_enable  (retry_enable),
        .grant_valid   (grant_valid),
        .grant_high    (grant_high),
        .grant_srcid   (grant_srcid),
        .retryack_won  (retryack_won),
        .pcrdgnt_won   (pcrdgnt_won),
        .grant_taken   (grant_taken),
        .retryack_valid(retryack_valid),
        .retryack      (retryack),
        .pcrdgnt_valid (pcrdgnt_valid),
        .pcrdgnt       (pcrdgnt)
    );

endmodule

`default_nettype wire

/* mshr_admit.sv */
// static requests assume a reserved entry exists, otherwise they land on index 0
// retire_idx must name an entry that is currently allocated
`timescale 1ns/10ps
`default_nettype none

module mshr_admit (
    input  wire                           clk,
    input  wire                           rst,
    input  wire hni_qos_pkg::req_info_t   req_info,
    input  wire chi_flit_pkg::req_flit_t  rxreq_flit,
    input  wire                           retire_valid,
    input  wire hni_qos_pkg::mshr_idx_t   retire_idx,
    input  wire                           high_present,
    input  wire                           low_present,
    output logic                          alloc_en,
    output chi_flit_pkg::req_flit_t       alloc_flit,
    output hni_qos_pkg::mshr_idx_t        alloc_idx,
    output logic                          retry_enable,
    output hni_qos_pkg::retire_t          retire
);

    hni_qos_pkg::mshr_vec_t entry_valid, reserved, stat_clr, class_high_q;
    hni_qos_pkg::mshr_vec_t alloc_vec, ret_vec, keep_vec;
    hni_qos_pkg::pool_cnt_t high_cnt, low_cnt;
    hni_qos_pkg::mshr_idx_t dyn_idx, stat_idx;
    logic take_high, take_low, dyn_alloc;
    logic ret_class_high, keep, high_dec, low_dec;

    function automatic hni_qos_pkg::mshr_idx_t first_idx(input hni_qos_pkg::mshr_vec_t v);
        hni_qos_pkg::mshr_idx_t idx;
        idx = '0;
        for (int i = hni_qos_pkg::MSHR_ENTRIES - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = hni_qos_pkg::mshr_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // high spills into the low pool, low never borrows from high
    assign take_high = req_info.dyn & req_info.high & (high_cnt != hni_qos_pkg::HIGH_POOL_NUM);
    assign take_low  = req_info.dyn & ~take_high & (low_cnt != hni_qos_pkg::LOW_POOL_NUM);
    assign dyn_alloc = take_high | take_low;

    assign retry_enable = req_info.dyn & ~dyn_alloc;
    assign alloc_en     = dyn_alloc | req_info.stat;
    assign alloc_flit   = alloc_en ? rxreq_flit : '0;

    assign dyn_idx   = first_idx(~entry_valid & ~reserved);
    assign stat_idx  = first_idx(~entry_valid & reserved);
    assign alloc_idx = req_info.stat ? stat_idx : dyn_idx;
    assign alloc_vec = alloc_en ? (hni_qos_pkg::mshr_vec_t'(1) << alloc_idx) : '0;

    // retiring entry is held for a waiting retry of a class it may serve
    assign ret_class_high = class_high_q[retire_idx];
    assign keep = retire_valid & (ret_class_high ? high_present : (high_present | low_present));
    assign high_dec = retire_valid & ret_class_high & ~keep;
    assign low_dec  = retire_valid & ~ret_class_high & ~keep;

    assign ret_vec  = retire_valid ? (hni_qos_pkg::mshr_vec_t'(1) << retire_idx) : '0;
    assign keep_vec = {hni_qos_pkg::MSHR_ENTRIES{keep}} & ret_vec;

    assign retire = '{valid: retire_valid, idx: retire_idx, class_high: ret_class_high};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_valid <= '0;
            reserved    <= '0;
            stat_clr    <= '0;
            high_cnt    <= '0;
            low_cnt     <= '0;
        end else begin
            entry_valid <= (entry_valid & ~ret_vec) | alloc_vec;
            reserved    <= (reserved & ~stat_clr) | keep_vec;
            stat_clr    <= req_info.stat ? alloc_vec : '0;
            high_cnt    <= high_cnt + hni_qos_pkg::pool_cnt_t'(take_high)
                           - hni_qos_pkg::pool_cnt_t'(high_dec);
            low_cnt     <= low_cnt + hni_qos_pkg::pool_cnt_t'(take_low)
                           - hni_qos_pkg::pool_cnt_t'(low_dec);
        end
    end

    // pool class of dynamic entries, static reuse keeps the old class
    always_ff @(posedge clk) begin
        if (dyn_alloc) begin
            class_high_q[alloc_idx] <= take_high;
        end
    end

endmodule

`default_nettype wire

/* pcrd_issue.sv */
// items offered to a full queue without a same-cycle pop are dropped
// pcrdtype bit 1 marks the high class, bit 0 the low class
`timescale 1ns/10ps
`default_nettype none

module pcrd_issue (
    input  wire                          clk,
    input  wire                          rst,
    input  wire hni_qos_pkg::req_info_t  req_info,
    input  wire                          retry_enable,
    input  wire                          grant_valid,
    input  wire                          grant_high,
    input  wire chi_flit_pkg::srcid_t    grant_srcid,
    input  wire                          retryack_won,
    input  wire                          pcrdgnt_won,
    output logic                         grant_taken,
    output logic                         retryack_valid,
    output chi_flit_pkg::retry_ack_t     retryack,
    output logic                         pcrdgnt_valid,
    output chi_flit_pkg::pcrd_grant_t    pcrdgnt
);

    chi_flit_pkg::retry_ack_t  ack_in;
    chi_flit_pkg::pcrd_grant_t gnt_in;
    logic ack_push, ack_pop, ack_empty, ack_full;
    logic gnt_push, gnt_pop, gnt_empty, gnt_full;

    assign ack_in = '{srcid:    req_info.srcid,
                      txnid:    req_info.txnid,
                      qos:      req_info.qos,
                      pcrdtype: chi_flit_pkg::pcrdtype_t'({req_info.high, req_info.low})};

    assign gnt_in = '{srcid:    grant_srcid,
                      qos:      grant_high ? hni_qos_pkg::GRANT_QOS_HIGH
                                           : hni_qos_pkg::GRANT_QOS_LOW,
                      pcrdtype: chi_flit_pkg::pcrdtype_t'({grant_high, ~grant_high})};

    assign ack_push = retry_enable & (~ack_full | retryack_won);
    assign ack_pop  = retryack_won & ~ack_empty;
    assign gnt_push = grant_valid & (~gnt_full | pcrdgnt_won);
    assign gnt_pop  = pcrdgnt_won & ~gnt_empty;

    // retry bank only decrements what actually got queued
    assign grant_taken = gnt_push;

    rsp_fifo #(.WIDTH($bits(chi_flit_pkg::retry_ack_t))) u_ack_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (ack_push),
        .pop     (ack_pop),
        .data_in (ack_in),
        .data_out(retryack),
        .empty   (ack_empty),
        .full    (ack_full)
    );

    rsp_fifo #(.WIDTH($bits(chi_flit_pkg::pcrd_grant_t))) u_gnt_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (gnt_push),
        .pop     (gnt_pop),
        .data_in (gnt_in),
        .data_out(pcrdgnt),
        .empty   (gnt_empty),
        .full    (gnt_full)
    );

    assign retryack_valid = ~ack_empty;
    assign pcrdgnt_valid  = ~gnt_empty;

endmodule

`default_nettype wire

/* req_decode.sv */
// all fields are zero while rxreq_valid is low
`timescale 1ns/10ps
`default_nettype none

module req_decode (
    input  wire                         rxreq_valid,
    input  wire chi_flit_pkg::req_flit_t rxreq_flit,
    output hni_qos_pkg::req_info_t      req_info
);

    always_comb begin
        req_info = '0;
        if (rxreq_valid) begin
            req_info.valid = 1'b1;
            // allowretry set means the requester can be bounced
            req_info.dyn   = rxreq_flit.allowretry;
            req_info.stat  = ~rxreq_flit.allowretry;
            req_info.high  = (rxreq_flit.qos >= hni_qos_pkg::QOS_HIGH_MIN);
            req_info.low   = (rxreq_flit.qos <= hni_qos_pkg::QOS_LOW_MAX);
            req_info.srcid = rxreq_flit.srcid;
            req_info.txnid = rxreq_flit.txnid;
            req_info.qos   = rxreq_flit.qos;
        end
    end

endmodule

`default_nettype wire

/* retry_bank.sv */
// bank entries are reused in rotation, so more distinct retrying sources than
// RET_BANK_ENTRIES can merge counts; counts do not saturate
`timescale 1ns/10ps
`default_nettype none

module retry_bank (
    input  wire                          clk,
    input  wire                          rst,
    input  wire hni_qos_pkg::req_info_t  req_info,
    input  wire                          retry_enable,
    input  wire hni_qos_pkg::retire_t    retire,
    input  wire                          grant_taken,
    output logic                         high_present,
    output logic                         low_present,
    output logic                         grant_valid,
    output logic                         grant_high,
    output chi_flit_pkg::srcid_t         grant_srcid
);

    chi_flit_pkg::srcid_t   bank_srcid [hni_qos_pkg::RET_BANK_ENTRIES];
    hni_qos_pkg::ret_cnt_t  cnt_h [hni_qos_pkg::RET_BANK_ENTRIES];
    hni_qos_pkg::ret_cnt_t  cnt_l [hni_qos_pkg::RET_BANK_ENTRIES];
    hni_qos_pkg::ret_vec_t  bank_v, match, inc_vec, h_dec, l_dec, h_left, l_left;
    hni_qos_pkg::ret_idx_t  next_ptr, inc_idx, win_idx;
    logic alloc_new, win_h, win_l;

    function automatic hni_qos_pkg::ret_idx_t first_idx(input hni_qos_pkg::ret_vec_t v);
        hni_qos_pkg::ret_idx_t idx;
        idx = '0;
        for (int i = hni_qos_pkg::RET_BANK_ENTRIES - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = hni_qos_pkg::ret_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // known source reuses its entry, new source takes the rotation slot
    assign alloc_new = retry_enable & ~(|match);
    assign inc_idx   = (|match) ? first_idx(match) : next_ptr;
    assign inc_vec   = retry_enable ? (hni_qos_pkg::ret_vec_t'(1) << inc_idx) : '0;

    // left vectors look past a decrement landing this cycle
    always_comb begin
        for (int i = 0; i < hni_qos_pkg::RET_BANK_ENTRIES; i++) begin
            match[i]  = bank_v[i] & (bank_srcid[i] == req_info.srcid);
            h_dec[i]  = grant_taken & grant_high & (win_idx == i);
            l_dec[i]  = grant_taken & ~grant_high & (win_idx == i);
            h_left[i] = (cnt_h[i] > hni_qos_pkg::ret_cnt_t'(h_dec[i]))
                        | (inc_vec[i] & req_info.high);
            l_left[i] = (cnt_l[i] > hni_qos_pkg::ret_cnt_t'(l_dec[i]))
                        | (inc_vec[i] & req_info.low);
        end
    end

    assign high_present = |h_left;
    assign low_present  = |l_left;

    // high always beats low
    assign win_h = retire.valid & high_present;
    assign win_l = retire.valid & ~retire.class_high & low_present & ~win_h;

    assign grant_srcid = bank_srcid[win_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank_v      <= '0;
            next_ptr    <= '0;
            win_idx     <= '0;
            grant_valid <= 1'b0;
            grant_high  <= 1'b0;
            for (int i = 0; i < hni_qos_pkg::RET_BANK_ENTRIES; i++) begin
                cnt_h[i] <= '0;
                cnt_l[i] <= '0;
            end
        end else begin
            if (alloc_new) begin
                bank_v[next_ptr] <= 1'b1;
                next_ptr         <= next_ptr + 1'b1;
            end
            grant_valid <= win_h | win_l;
            grant_high  <= win_h;
            if (win_h | win_l) begin
                win_idx <= win_h ? first_idx(h_left) : first_idx(l_left);
            end
            for (int i = 0; i < hni_qos_pkg::RET_BANK_ENTRIES; i++) begin
                cnt_h[i] <= cnt_h[i] + hni_qos_pkg::ret_cnt_t'(inc_vec[i] & req_info.high)
                            - hni_qos_pkg::ret_cnt_t'(h_dec[i]);
                cnt_l[i] <= cnt_l[i] + hni_qos_pkg::ret_cnt_t'(inc_vec[i] & req_info.low)
                            - hni_qos_pkg::ret_cnt_t'(l_dec[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_new) begin
            bank_srcid[next_ptr] <= req_info.srcid;
        end
    end

endmodule

`default_nettype wire

/* rsp_fifo.sv */
// RSP_FIFO_DEPTH must be a power of two; push while full only with a pop
`timescale 1ns/10ps
`default_nettype none

module rsp_fifo #(
    parameter int WIDTH = 8
) (
    input  wire              clk,
    input  wire              rst,
    input  wire              push,
    input  wire              pop,
    input  wire [WIDTH-1:0]  data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);

    logic [WIDTH-1:0] mem [hni_qos_pkg::RSP_FIFO_DEPTH];
    logic [$clog2(hni_qos_pkg::RSP_FIFO_DEPTH)-1:0]   wr_ptr, rd_ptr;
    logic [$clog2(hni_qos_pkg::RSP_FIFO_DEPTH+1)-1:0] count;

    assign data_out = mem[rd_ptr];
    assign empty    = (count == 0);
    assign full     = (count == hni_qos_pkg::RSP_FIFO_DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
chi_flit_pkg.sv
hni_qos_pkg.sv
rsp_fifo.sv
req_decode.sv
mshr_admit.sv
retry_bank.sv
pcrd_issue.sv
hni_qos_top.sv
tb_hni_qos.sv

/* tb_hni_qos_tasks.svh */
// stimulus, compare and directed test tasks for tb_hni_qos
// outputs sampled on the falling edge and inputs driven on the rising edge
`ifndef TB_HNI_QOS_TASKS_SVH
`define TB_HNI_QOS_TASKS_SVH

// taps x^32 + x^22 + x^2 + x + 1 and one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        val        = {val[30:0], fb};
    end
    return val;
endfunction

function automatic chi_flit_pkg::srcid_t new_srcid();
    return chi_flit_pkg::srcid_t'(rand_bits(7));
endfunction

function automatic chi_flit_pkg::srcid_t other_srcid(input chi_flit_pkg::srcid_t avoid);
    chi_flit_pkg::srcid_t s;
    s = new_srcid();
    while (s == avoid) begin
        s = new_srcid();
    end
    return s;
endfunction

function automatic chi_flit_pkg::req_flit_t make_flit(input chi_flit_pkg::qos_t qos,
                                                      input chi_flit_pkg::srcid_t srcid,
                                                      input logic allowretry);
    chi_flit_pkg::req_flit_t f;
    f            = '0;
    f.qos        = qos;
    f.tgtid      = 7'h10;
    f.srcid      = srcid;
    f.txnid      = chi_flit_pkg::txnid_t'(rand_bits(12));
    f.opcode     = 7'h04;
    f.addr       = 44'h0_0100_0040;
    f.allowretry = allowretry;
    return f;
endfunction

task automatic check_bit(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
endtask

task automatic check_idx(input string name, input hni_qos_pkg::mshr_idx_t exp,
                         input hni_qos_pkg::mshr_idx_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
    end
endtask

task automatic check_flit(input string name, input chi_flit_pkg::req_flit_t exp,
                          input chi_flit_pkg::req_flit_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_retry_ack(input string name, input chi_flit_pkg::retry_ack_t exp,
                               input chi_flit_pkg::retry_ack_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_grant(input string name, input chi_flit_pkg::pcrd_grant_t exp,
                           input chi_flit_pkg::pcrd_grant_t act);
    check_count++;
    if (act !== exp) begin
        error_count++;
        $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
endtask

// one-cycle request with admission outputs read at the following falling edge
task automatic drive_req(input chi_flit_pkg::req_flit_t flit);
    @(posedge clk);
    rxreq_valid <= 1'b1;
    rxreq_flit  <= flit;
    @(negedge clk);
endtask

task automatic release_req();
    @(posedge clk);
    rxreq_valid <= 1'b0;
    rxreq_flit  <= '0;
endtask

task automatic expect_alloc(input string name, input chi_flit_pkg::req_flit_t flit,
                            input hni_qos_pkg::mshr_idx_t exp_idx);
    drive_req(flit);
    check_bit({name, " alloc_en"}, 1'b1, alloc_en);
    check_bit({name, " retry_enable"}, 1'b0, retry_enable);
    check_idx({name, " alloc_idx"}, exp_idx, alloc_idx);
    check_flit({name, " alloc_flit"}, flit, alloc_flit);
    release_req();
endtask

task automatic expect_reject(input string name, input chi_flit_pkg::req_flit_t flit);
    drive_req(flit);
    check_bit({name, " alloc_en"}, 1'b0, alloc_en);
    check_bit({name, " retry_enable"}, 1'b1, retry_enable);
    release_req();
endtask

// dynamic requests of one QoS taking consecutive indices
task automatic fill(input string name, input chi_flit_pkg::qos_t qos,
                    input int first, input int count);
    for (int i = 0; i < count; i++) begin
        expect_alloc(name, make_flit(qos, new_srcid(), 1'b1),
                     hni_qos_pkg::mshr_idx_t'(first + i));
    end
endtask

task automatic retire_entry(input hni_qos_pkg::mshr_idx_t idx);
    @(posedge clk);
    retire_valid <= 1'b1;
    retire_idx   <= idx;
    @(posedge clk);
    retire_valid <= 1'b0;
endtask

task automatic pop_ack();
    @(posedge clk);
    retryack_won <= 1'b1;
    @(posedge clk);
    retryack_won <= 1'b0;
endtask

task automatic pop_grant();
    @(posedge clk);
    pcrdgnt_won <= 1'b1;
    @(posedge clk);
    pcrdgnt_won <= 1'b0;
endtask

// call right after a rejection into an empty ack queue
task automatic expect_ack(input string name, input chi_flit_pkg::req_flit_t flit,
                          input chi_flit_pkg::pcrdtype_t pcrdtype);
    chi_flit_pkg::retry_ack_t exp;
    exp = '{srcid: flit.srcid, txnid: flit.txnid, qos: flit.qos, pcrdtype: pcrdtype};
    @(negedge clk);
    check_bit({name, " retryack_valid"}, 1'b1, retryack_valid);
    check_retry_ack({name, " retryack"}, exp, retryack);
    pop_ack();
    @(negedge clk);
    check_bit({name, " retryack_valid after pop"}, 1'b0, retryack_valid);
endtask

// call right after retire_entry since the grant lands two cycles after the strobe
task automatic expect_grant(input string name, input chi_flit_pkg::srcid_t srcid,
                            input logic high);
    chi_flit_pkg::pcrd_grant_t exp;
    exp.srcid    = srcid;
    exp.qos      = high ? 4'd15 : 4'd0;
    exp.pcrdtype = high ? 4'd2 : 4'd1;
    @(negedge clk);
    check_bit({name, " pcrdgnt_valid early"}, 1'b0, pcrdgnt_valid);
    @(negedge clk);
    check_bit({name, " pcrdgnt_valid"}, 1'b1, pcrdgnt_valid);
    check_grant({name, " pcrdgnt"}, exp, pcrdgnt);
    pop_grant();
    @(negedge clk);
    check_bit({name, " pcrdgnt_valid after pop"}, 1'b0, pcrdgnt_valid);
endtask

task automatic test_low_fill();
    apply_reset();
    fill("low fill", 4'd3, 0, 4);
    expect_reject("low fill fifth", make_flit(4'd3, new_srcid(), 1'b1));
endtask

task automatic test_high_fill();
    apply_reset();
    // high pool first and then spill into the low pool
    fill("high fill", 4'd12, 0, 8);
    expect_reject("high fill ninth", make_flit(4'd12, new_srcid(), 1'b1));
endtask

task automatic test_retry_ack();
    chi_flit_pkg::req_flit_t f;
    apply_reset();
    fill("ack low fill", 4'd3, 0, 4);
    f = make_flit(4'd5, new_srcid(), 1'b1);
    expect_reject("ack low reject", f);
    expect_ack("ack low", f, 4'd1);
    fill("ack high fill", 4'd12, 4, 4);
    f = make_flit(4'd10, new_srcid(), 1'b1);
    expect_reject("ack high reject", f);
    expect_ack("ack high", f, 4'd2);
endtask

task automatic test_credit_grant();
    chi_flit_pkg::req_flit_t f;
    apply_reset();
    fill("grant fill", 4'd12, 0, 8);
    f = make_flit(4'd12, new_srcid(), 1'b1);
    expect_reject("grant reject", f);
    retire_entry(3'd1);
    expect_grant("grant high", f.srcid, 1'b1);
    // nothing pending now so entry 2 goes back to the free list
    retire_entry(3'd2);
    repeat (2) @(negedge clk);
    check_bit("grant none pcrdgnt_valid", 1'b0, pcrdgnt_valid);
    expect_alloc("grant realloc", make_flit(4'd12, new_srcid(), 1'b1), 3'd2);
endtask

task automatic test_static_realloc();
    chi_flit_pkg::srcid_t src;
    apply_reset();
    fill("static fill", 4'd12, 0, 8);
    src = new_srcid();
    expect_reject("static reject", make_flit(4'd12, src, 1'b1));
    // low-pool entry held for the high retry
    retire_entry(3'd5);
    expect_grant("static grant", src, 1'b1);
    expect_alloc("static alloc", make_flit(4'd12, src, 1'b0), 3'd5);
    expect_reject("static pools full", make_flit(4'd12, new_srcid(), 1'b1));
endtask

task automatic test_grant_priority();
    chi_flit_pkg::srcid_t src_l;
    chi_flit_pkg::srcid_t src_h;
    apply_reset();
    fill("prio high fill", 4'd12, 0, 4);
    fill("prio low fill", 4'd2, 4, 4);
    src_l = new_srcid();
    src_h = other_srcid(src_l);
    expect_reject("prio low reject", make_flit(4'd2, src_l, 1'b1));
    expect_reject("prio high reject", make_flit(4'd9, src_h, 1'b1));
    retire_entry(3'd4);
    expect_grant("prio first grant", src_h, 1'b1);
    expect_reject("prio repeat reject 1", make_flit(4'd9, src_h, 1'b1));
    expect_reject("prio repeat reject 2", make_flit(4'd9, src_h, 1'b1));
    retire_entry(3'd0);
    expect_grant("prio repeat grant 1", src_h, 1'b1);
    retire_entry(3'd1);
    expect_grant("prio repeat grant 2", src_h, 1'b1);
    // only the low retry is left, served by a low-class retire
    retire_entry(3'd5);
    expect_grant("prio low grant", src_l, 1'b0);
endtask

`endif

/* tb_hni_qos.sv */
// directed testbench for the QoS admission block, one request in flight at a time
// every test starts from reset, so no state carries over between tests
`timescale 1ns/10ps
`default_nettype none

module tb_hni_qos;

    localparam int NUM_TESTS = 6;
    localparam int CYCLES_PER_TEST = 200;

    logic                      clk = 1'b0;
    logic                      rst;
    logic                      rxreq_valid;
    chi_flit_pkg::req_flit_t   rxreq_flit;
    logic                      retryack_won;
    logic                      pcrdgnt_won;
    logic                      retire_valid;
    hni_qos_pkg::mshr_idx_t    retire_idx;
    logic                      alloc_en;
    chi_flit_pkg::req_flit_t   alloc_flit;
    hni_qos_pkg::mshr_idx_t    alloc_idx;
    logic                      retry_enable;
    logic                      retryack_valid;
    chi_flit_pkg::retry_ack_t  retryack;
    logic                      pcrdgnt_valid;
    chi_flit_pkg::pcrd_grant_t pcrdgnt;

    logic [31:0] lfsr_state = 32'hf7527b53;
    int check_count = 0;
    int error_count = 0;

    always #5 clk = ~clk;

    hni_qos_top UUT (
        .clk           (clk),
        .rst           (rst),
        .rxreq_valid   (rxreq_valid),
        .rxreq_flit    (rxreq_flit),
        .retryack_won  (retryack_won),
        .pcrdgnt_won   (pcrdgnt_won),
        .retire_valid  (retire_valid),
        .retire_idx    (retire_idx),
        .alloc_en      (alloc_en),
        .alloc_flit    (alloc_flit),
        .alloc_idx     (alloc_idx),
        .retry_enable  (retry_enable),
        .retryack_valid(retryack_valid),
        .retryack      (retryack),
        .pcrdgnt_valid (pcrdgnt_valid),
        .pcrdgnt       (pcrdgnt)
    );

    `include "tb_hni_qos_tasks.svh"

    initial begin
        rst          = 1'b1;
        rxreq_valid  = 1'b0;
        rxreq_flit   = '0;
        retryack_won = 1'b0;
        pcrdgnt_won  = 1'b0;
        retire_valid = 1'b0;
        retire_idx   = '0;
        test_low_fill();
        test_high_fill();
        test_retry_ack();
        test_credit_grant();
        test_static_realloc();
        test_grant_priority();
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("timeout: tests did not complete within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
